// File: adc_defs.svh
`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

// Channel count and converter resolution
`define ADC_NUM_CH      2
`define ADC_RES_BITS    12
`define ANALOG_W        32      // Raw analog word from the converter model

// APB address map
`define APB_ADDR_W      16
`define SLOT_LSB        12      // Peripheral slot in paddr[15:12]
`define SLOT_W          4
`define REG_OFS_LSB     2       // Word offset in paddr[3:2]

// Conversion timing
`define CONV_CYCLES     8       // conv_start to conv_done
`define CNT_W           16      // Conversion counter width

`endif

// File: adc_pkg.sv
`include "adc_defs.svh"

package adc_pkg;

        // One converted sample
        typedef logic [`ADC_RES_BITS-1:0] sample_t;

        // One APB bus word
        typedef logic [31:0] apb_data_t;

        // Completed conversion counter
        typedef logic [`CNT_W-1:0] conv_count_t;

        // Word offsets inside a channel, offset 3 reserved
        typedef enum logic [1:0] {
                CTRL  = 2'd0,
                DATA  = 2'd1,
                COUNT = 2'd2
        } reg_offset_e;

endpackage

// File: apb_slot_decode.sv
`timescale 1ns/100ps
`include "adc_defs.svh"

module apb_slot_decode #(
        parameter int NUM_CH = `ADC_NUM_CH
) (
        input  logic [`APB_ADDR_W-1:0] paddr,
        output logic [NUM_CH-1:0]      slot_sel
);

        logic [`SLOT_W-1:0] slot;

        assign slot = paddr[`SLOT_LSB +: `SLOT_W];

        // One-hot select, all low for slots past the last channel
        always_comb begin
                for (int i = 0; i < NUM_CH; i++) begin
                        slot_sel[i] = (slot == `SLOT_W'(i));
                end
        end

endmodule

// File: adc_conv_seq.sv
`timescale 1ns/100ps
`include "adc_defs.svh"

module adc_conv_seq #(
        parameter int NUM_CH = `ADC_NUM_CH
) (
        input  logic              clk,
        input  logic              RSTn,
        input  logic [NUM_CH-1:0] ch_enable,
        output logic              conv_start,
        output logic              conv_done
);

        localparam int CW = $clog2(`CONV_CYCLES + 1);

        typedef enum logic {
                S_IDLE,
                S_CONV
        } state_e;

        state_e        state;
        logic [CW-1:0] cnt;     // Cycles left until end of conversion

        //------------------------------------------------------------
        // Start/EOC pulse generator shared by every channel
        //------------------------------------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        state      <= S_IDLE;
                        cnt        <= '0;
                        conv_start <= 1'b0;
                        conv_done  <= 1'b0;
                end else begin
                        conv_start <= 1'b0;     // Both are single-cycle pulses
                        conv_done  <= 1'b0;
                        case (state)
                        S_IDLE: begin
                                if (|ch_enable) begin
                                        state      <= S_CONV;
                                        conv_start <= 1'b1;
                                        cnt        <= CW'(`CONV_CYCLES);
                                end
                        end
                        S_CONV: begin
                                // Runs to the end even if the enables drop
                                cnt <= cnt - 1'b1;
                                if (cnt == CW'(1)) begin
                                        conv_done <= 1'b1;
                                        state     <= S_IDLE;
                                end
                        end
                        default: state <= S_IDLE;
                        endcase
                end
        end

endmodule

// File: adc_channel.sv
`timescale 1ns/100ps
`include "adc_defs.svh"

module adc_channel (
        input  logic                   clk,
        input  logic                   RSTn,
        input  logic                   sel,
        input  logic                   penable,
        input  logic                   pwrite,
        input  logic [`APB_ADDR_W-1:0] paddr,
        input  adc_pkg::apb_data_t     pwdata,
        input  logic [`ANALOG_W-1:0]   analog_in,
        input  logic                   conv_start,
        input  logic                   conv_done,
        output adc_pkg::apb_data_t     rdata,
        output logic                   enable
);

        adc_pkg::reg_offset_e  ofs;
        logic                  wr_ctrl;

        logic                  ctrl_en;        // CTRL bit 0
        adc_pkg::sample_t      data_q;
        adc_pkg::conv_count_t  count_q;
        logic                  armed;
        adc_pkg::sample_t      pending;        // Sample held until EOC

        assign ofs     = adc_pkg::reg_offset_e'(paddr[`REG_OFS_LSB +: 2]);
        assign wr_ctrl = sel && penable && pwrite && (ofs == adc_pkg::CTRL);
        assign enable  = ctrl_en;

        //------------------------------------------------------------
        // Control register, only bit 0 is writable
        //------------------------------------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn)
                        ctrl_en <= 1'b0;
                else if (wr_ctrl)
                        ctrl_en <= pwdata[0];
        end

        //------------------------------------------------------------
        // Conversion capture and commit
        //------------------------------------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        armed   <= 1'b0;
                        data_q  <= '0;
                        count_q <= '0;
                end else if (conv_start && ctrl_en) begin
                        armed <= 1'b1;
                end else if (conv_done && armed) begin
                        armed   <= 1'b0;
                        data_q  <= pending;
                        count_q <= count_q + 1'b1;      // Wraps
                end
        end

        // Quantize by keeping the top bits of the analog word
        always_ff @(posedge clk) begin
                if (conv_start && ctrl_en)
                        pending <= analog_in[`ANALOG_W-1 -: `ADC_RES_BITS];
        end

        // Read data, zero when not selected or reserved offset
        always_comb begin
                rdata = '0;
                if (sel) begin
                        case (ofs)
                        adc_pkg::CTRL:  rdata[0] = ctrl_en;
                        adc_pkg::DATA:  rdata[`ADC_RES_BITS-1:0] = data_q;
                        adc_pkg::COUNT: rdata[`CNT_W-1:0] = count_q;
                        default:        rdata = '0;
                        endcase
                end
        end

endmodule

// File: apb_read_mux.sv
`timescale 1ns/100ps
`include "adc_defs.svh"

module apb_read_mux #(
        parameter int NUM_CH = `ADC_NUM_CH
) (
        input  logic                            psel,
        input  logic                            penable,
        input  logic [NUM_CH-1:0]               slot_sel,
        input  adc_pkg::apb_data_t [NUM_CH-1:0] ch_rdata,
        output adc_pkg::apb_data_t              prdata,
        output logic                            pready,
        output logic                            pslverr
);

        // At most one select is high, so OR the gated words
        always_comb begin
                prdata = '0;
                for (int i = 0; i < NUM_CH; i++) begin
                        if (slot_sel[i])
                                prdata = prdata | ch_rdata[i];
                end
        end

        assign pready = 1'b1;   // Zero wait states

        // No channel hit means an unmapped slot
        assign pslverr = psel && penable && !(|slot_sel);

endmodule

// File: adc_apb_subsys.sv
`timescale 1ns/100ps
`include "adc_defs.svh"

module adc_apb_subsys (
        input  logic                                     clk,
        input  logic                                     RSTn,
        input  logic                                     psel,
        input  logic                                     penable,
        input  logic                                     pwrite,
        input  logic [`APB_ADDR_W-1:0]                   paddr,
        input  adc_pkg::apb_data_t                       pwdata,
        input  logic [`ADC_NUM_CH-1:0][`ANALOG_W-1:0]    analog_in,
        output adc_pkg::apb_data_t                       prdata,
        output logic                                     pready,
        output logic                                     pslverr,
        output logic                                     conv_start,
        output logic                                     conv_done
);

        logic [`ADC_NUM_CH-1:0]               slot_sel;
        logic [`ADC_NUM_CH-1:0]               ch_enable;
        adc_pkg::apb_data_t [`ADC_NUM_CH-1:0] ch_rdata;

        //------------------------------------------------------------
        // Slot decode and shared sequencer
        //------------------------------------------------------------
        apb_slot_decode #(.NUM_CH(`ADC_NUM_CH)) u_decode (
                .paddr      (paddr),
                .slot_sel   (slot_sel)
        );

        adc_conv_seq #(.NUM_CH(`ADC_NUM_CH)) u_seq (
                .clk        (clk),
                .RSTn       (RSTn),
                .ch_enable  (ch_enable),
                .conv_start (conv_start),
                .conv_done  (conv_done)
        );

        //------------------------------------------------------------
        // Channels
        //------------------------------------------------------------
        for (genvar i = 0; i < `ADC_NUM_CH; i++) begin : g_ch
                adc_channel u_ch (
                        .clk        (clk),
                        .RSTn       (RSTn),
                        .sel        (slot_sel[i]),
                        .penable    (penable),
                        .pwrite     (pwrite),
                        .paddr      (paddr),
                        .pwdata     (pwdata),
                        .analog_in  (analog_in[i]),
                        .conv_start (conv_start),
                        .conv_done  (conv_done),
                        .rdata      (ch_rdata[i]),
                        .enable     (ch_enable[i])
                );
        end

        apb_read_mux #(.NUM_CH(`ADC_NUM_CH)) u_mux (
                .psel       (psel),
                .penable    (penable),
                .slot_sel   (slot_sel),
                .ch_rdata   (ch_rdata),
                .prdata     (prdata),
                .pready     (pready),
                .pslverr    (pslverr)
        );

endmodule

// File: adc_apb_subsys_props.sv
`timescale 1ns/100ps

module adc_apb_subsys_props (
        input logic clk,
        input logic RSTn,
        input logic psel,
        input logic penable,
        input logic pready,
        input logic pslverr,
        input logic conv_start,
        input logic conv_done
);

        // Zero wait states on every transfer
        a_ready_high: assert property (@(posedge clk) disable iff (!RSTn) pready)
                else $error("pready went low");

        a_err_access: assert property (@(posedge clk) disable iff (!RSTn)
                pslverr |-> (psel && penable))
                else $error("pslverr raised outside the access phase");

        //------------------------------------------------------------
        // Sequencer pulses
        //------------------------------------------------------------
        a_no_overlap: assert property (@(posedge clk) disable iff (!RSTn)
                !(conv_start && conv_done))
                else $error("conv_start and conv_done high in the same cycle");

        a_done_pulse: assert property (@(posedge clk) disable iff (!RSTn)
                conv_done |=> !conv_done)
                else $error("conv_done held longer than one cycle");

endmodule

bind adc_apb_subsys adc_apb_subsys_props u_props (
        .clk        (clk),
        .RSTn       (RSTn),
        .psel       (psel),
        .penable    (penable),
        .pready     (pready),
        .pslverr    (pslverr),
        .conv_start (conv_start),
        .conv_done  (conv_done)
);

// File: tb_adc_apb_subsys.sv
`timescale 1ns/100ps
`include "adc_defs.svh"

module tb_adc_apb_subsys;

        localparam int NUM_XFERS      = 400;       // Random transfers
        localparam int NUM_DIRECTED   = 2 * (`ADC_NUM_CH + 1) * 4 + `ADC_NUM_CH;
        localparam int TIMEOUT_CYCLES = (NUM_XFERS + NUM_DIRECTED) * 4 + 1000;

        logic                                  clk;
        logic                                  RSTn;
        logic                                  psel;
        logic                                  penable;
        logic                                  pwrite;
        logic [`APB_ADDR_W-1:0]                paddr;
        adc_pkg::apb_data_t                    pwdata;
        logic [`ADC_NUM_CH-1:0][`ANALOG_W-1:0] analog_in;
        adc_pkg::apb_data_t                    prdata;
        logic                                  pready;
        logic                                  pslverr;
        logic                                  conv_start;
        logic                                  conv_done;

        integer seed;
        int     errors;
        int     checks;

        // Reference model state
        logic [`ADC_NUM_CH-1:0] m_ctrl;
        logic [`ADC_NUM_CH-1:0] m_armed;
        adc_pkg::sample_t       m_data[`ADC_NUM_CH];
        adc_pkg::sample_t       m_pending[`ADC_NUM_CH];
        adc_pkg::conv_count_t   m_count[`ADC_NUM_CH];
        logic                   seq_busy;
        logic                   idle_prev;      // Sequencer idle in the last cycle
        logic                   any_en_prev;    // Some channel enabled in the last cycle
        int                     conv_cyc;

        adc_apb_subsys uut (
                .clk        (clk),
                .RSTn       (RSTn),
                .psel       (psel),
                .penable    (penable),
                .pwrite     (pwrite),
                .paddr      (paddr),
                .pwdata     (pwdata),
                .analog_in  (analog_in),
                .prdata     (prdata),
                .pready     (pready),
                .pslverr    (pslverr),
                .conv_start (conv_start),
                .conv_done  (conv_done)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                checks++;
                if (expected !== actual) begin
                        errors++;
                        $display("Error: %s expected %h actual %h at %0t", name, expected,
                                 actual, $time);
                end
        endtask

        // One clock with fresh analog words
        task automatic next_cycle();
                @(posedge clk);
                for (int i = 0; i < `ADC_NUM_CH; i++)
                        analog_in[i] <= $random(seed);
        endtask

        function automatic logic [`APB_ADDR_W-1:0] make_addr(input logic [3:0] slot,
                                                             input logic [1:0] ofs);
                logic [7:0] junk;
                junk = $random(seed);   // Bits the decoder must ignore
                return {slot, junk, ofs, 2'b00};
        endfunction

        // Setup cycle followed by access cycle
        task automatic apb_xfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                                input adc_pkg::apb_data_t data);
                next_cycle();
                psel    <= 1'b1;
                penable <= 1'b0;
                pwrite  <= wr;
                paddr   <= addr;
                pwdata  <= data;
                next_cycle();
                penable <= 1'b1;
                next_cycle();
                psel    <= 1'b0;
                penable <= 1'b0;
        endtask

        task automatic read_all_regs();
                for (int s = 0; s <= `ADC_NUM_CH; s++)
                        for (int o = 0; o < 4; o++)
                                apb_xfer(1'b0, make_addr(4'(s), 2'(o)), '0);
        endtask

        //------------------------------------------------------------
        // Reference model and checks on the falling edge
        //------------------------------------------------------------
        always @(negedge clk) begin : model_check
                logic [3:0]         slot;
                logic [1:0]         ofs;
                logic               unmapped;
                adc_pkg::apb_data_t exp_rd;
                logic               exp_start;
                logic               exp_done;

                slot     = paddr[`SLOT_LSB +: `SLOT_W];
                ofs      = paddr[3:2];
                unmapped = (slot >= `ADC_NUM_CH);
                check_value("pready", 32'(1'b1), 32'(pready));
                check_value("pslverr", 32'(psel && penable && unmapped), 32'(pslverr));
                if (psel && penable && !pwrite) begin
                        exp_rd = '0;
                        if (!unmapped) begin
                                case (ofs)
                                2'd0:    exp_rd = 32'(m_ctrl[slot]);
                                2'd1:    exp_rd = 32'(m_data[slot]);
                                2'd2:    exp_rd = 32'(m_count[slot]);
                                default: exp_rd = '0;
                                endcase
                        end
                        check_value("register read", exp_rd, prdata);
                end

                // Start only from idle with an enable
                exp_start = idle_prev && any_en_prev;
                if (seq_busy)
                        conv_cyc++;
                exp_done = seq_busy && (conv_cyc == `CONV_CYCLES);
                check_value("conv_start", 32'(exp_start), 32'(conv_start));
                check_value("conv_done timing", 32'(exp_done), 32'(conv_done));
                if (conv_start) begin
                        seq_busy = 1'b1;
                        conv_cyc = 0;
                end else if (conv_done) begin
                        seq_busy = 1'b0;
                end

                for (int i = 0; i < `ADC_NUM_CH; i++) begin
                        if (conv_start && m_ctrl[i]) begin
                                m_armed[i]   = 1'b1;
                                m_pending[i] = adc_pkg::sample_t'(analog_in[i] >>
                                               (`ANALOG_W - `ADC_RES_BITS));
                        end else if (conv_done && m_armed[i]) begin
                                m_armed[i] = 1'b0;
                                m_data[i]  = m_pending[i];
                                m_count[i] = m_count[i] + 1'b1;
                        end
                end
                any_en_prev = |m_ctrl;
                idle_prev   = !seq_busy;

                // Only CTRL bit 0 is writable
                if (psel && penable && pwrite && !unmapped && ofs == 2'd0)
                        m_ctrl[slot] = pwdata[0];
        end

        initial begin : watchdog
                repeat (TIMEOUT_CYCLES) @(posedge clk);
                $display("Watchdog expired after %0d cycles, the run did not finish",
                         TIMEOUT_CYCLES);
                $display("Test failed");
                $finish;
        end

        //------------------------------------------------------------
        // Stimulus
        //------------------------------------------------------------
        initial begin : stimulus
                logic [31:0] r;
                logic [3:0]  slot;

                seed        = 32'h5220f9d2;
                errors      = 0;
                checks      = 0;
                RSTn        = 1'b0;
                psel        = 1'b0;
                penable     = 1'b0;
                pwrite      = 1'b0;
                paddr       = '0;
                pwdata      = '0;
                analog_in   = '0;
                m_ctrl      = '0;
                m_armed     = '0;
                seq_busy    = 1'b0;
                idle_prev   = 1'b1;
                any_en_prev = 1'b0;
                conv_cyc    = 0;
                for (int i = 0; i < `ADC_NUM_CH; i++) begin
                        m_data[i]    = '0;
                        m_pending[i] = '0;
                        m_count[i]   = '0;
                end

                repeat (8) next_cycle();
                RSTn <= 1'b1;

                read_all_regs();        // Everything zero out of reset

                for (int n = 0; n < NUM_XFERS; n++) begin
                        r = $random(seed);
                        if (r[2:0] == 3'd0)     // Now and then an unmapped slot
                                slot = (r[15:12] < `ADC_NUM_CH) ? 4'(`ADC_NUM_CH) : r[15:12];
                        else
                                slot = 4'(r[7:3] % `ADC_NUM_CH);
                        apb_xfer(r[8], make_addr(slot, r[10:9]), $random(seed));
                end

                // With all channels off the sequencer stays quiet
                for (int i = 0; i < `ADC_NUM_CH; i++)
                        apb_xfer(1'b1, make_addr(4'(i), 2'd0), 32'hffff_fffe);
                repeat (4 * `CONV_CYCLES) next_cycle();
                read_all_regs();
                repeat (4) next_cycle();

                $display("Checks run: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("Test completed successfully");
                else
                        $display("Test failed");
                $finish;
        end

endmodule

// File: sim.f
+incdir+.
adc_pkg.sv
apb_slot_decode.sv
adc_conv_seq.sv
adc_channel.sv
apb_read_mux.sv
adc_apb_subsys.sv
adc_apb_subsys_props.sv
tb_adc_apb_subsys.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_adc_apb_subsys
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
PASS_MSG  ?= Test completed successfully

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
